// ==== sources.f ====
axi_bridge_pkg.sv
rd_channel_fsm.sv
wr_channel_fsm.sv
beat_counter.sv
wr_line_buffer.sv
axi_bridge_top.sv
tb_axi_mem.sv
tb_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_axi_bridge -f sources.f -o tb_axi_bridge

./obj_dir/tb_axi_bridge > sim.log
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== tb_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_axi_bridge
  import axi_bridge_pkg::*;
();

  localparam int n_inst = 60;
  localparam int n_data = 60;
  // a data op may be a write plus its read-back
  localparam int n_txn = 3 + n_inst + 2 * n_data;

  logic    aclk;
  logic    reset;
  logic    inst_rd_req;
  rd_req_t inst_rd;
  logic    inst_rd_rdy;
  logic    data_rd_req;
  rd_req_t data_rd;
  logic    data_rd_rdy;
  logic    data_wr_req;
  wr_req_t data_wr;
  logic    data_wr_rdy;
  rd_ret_t inst_ret;
  rd_ret_t data_ret;
  axi_ar_t ar;
  logic    arvalid;
  logic    arready;
  axi_r_t  r;
  logic    rvalid;
  logic    rready;
  axi_aw_t aw;
  logic    awvalid;
  logic    awready;
  axi_w_t  w;
  logic    wvalid;
  logic    wready;
  axi_b_t  b;
  logic    bvalid;
  logic    bready;

  logic [data_w-1:0] shadow [0:1023];
  int                value_errs, proto_errs, flow_errs;
  // per port read bookkeeping with index 0 for instruction and 1 for data
  logic              pend [2];
  logic [addr_w-1:0] base [2];
  int                beats [2];
  int                cnt [2];
  axi_ar_t           exp_ar;
  logic [3:0]        ar_ids [$];
  wr_req_t           wr_q;
  logic              wr_pend, wr_window;
  int                wr_beat, inst_in_window;

  axi_bridge_top dut (.*);

  tb_axi_mem mem_model (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  initial begin
    #(n_txn * 40 * 20);
    $display("timeout: run did not finish within %0d cycles", n_txn * 40);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [9:0] word_idx(input logic [addr_w-1:0] addr);
    return addr[11:2];
  endfunction

  function automatic int beat_count(input logic [2:0] req_type);
    return (req_type == rd_type_line) ? 4 : 1;
  endfunction

  function automatic axi_ar_t expect_addr(input logic [3:0] id, input logic [2:0] req_type,
                                          input logic [addr_w-1:0] addr);
    return '{id: id, addr: addr, len: (req_type == rd_type_line) ? 8'd3 : 8'd0,
             size: size_word, burst: burst_incr, lock: lock_normal, cache: cache_attr,
             prot: prot_attr};
  endfunction

  // word k of a line sits at bits 32k up
  function automatic axi_w_t expect_beat(input wr_req_t req, input int beat);
    return '{id: id_data, data: req.payload.line[beat*32 +: 32],
             strb: (req.req_type == rd_type_line) ? 4'hf : req.strb,
             last: (beat == beat_count(req.req_type) - 1)};
  endfunction

  function automatic bit bridge_idle();
    return {arvalid, awvalid, wvalid, rready, bready, inst_ret.valid, data_ret.valid} === 7'b0
           && {inst_rd_rdy, data_rd_rdy, data_wr_rdy} === 3'b111;
  endfunction

  function automatic rd_req_t random_read(input logic [addr_w-1:0] region);
    rd_req_t req;
    if ($urandom % 2 == 0) begin
      req.req_type = rd_type_line;
      req.addr     = region + 32'($urandom % 128) * 32'd16;
    end else begin
      req.req_type = 3'($urandom % 4);
      req.addr     = region + 32'($urandom % 512) * 32'd4;
    end
    return req;
  endfunction

  function automatic wr_req_t random_write(input logic [addr_w-1:0] region);
    rd_req_t where;
    wr_req_t req;
    where        = random_read(region);
    req.req_type = where.req_type;
    req.addr     = where.addr;
    req.strb     = 4'($urandom);
    req.payload.line = {$urandom, $urandom, $urandom, $urandom};
    return req;
  endfunction

  task automatic check_ret(input string name, input rd_ret_t got, input rd_ret_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("error at %0t: ar got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("error at %0t: aw got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_w(input axi_w_t got, input axi_w_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("error at %0t: w got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic protocol_fault(input string what);
    proto_errs++;
    $display("at %0t: %s", $time, what);
  endtask

  task automatic flow_fault(input string what);
    flow_errs++;
    $display("at %0t: %s", $time, what);
  endtask

  task automatic open_read(input int p, input logic [3:0] id, input rd_req_t req);
    exp_ar   = expect_addr(id, req.req_type, req.addr);
    pend[p]  = 1'b1;
    base[p]  = req.addr;
    beats[p] = beat_count(req.req_type);
    cnt[p]   = 0;
  endtask

  task automatic take_ret(input int p, input string name, input rd_ret_t got);
    if (!pend[p]) begin
      protocol_fault({name, " delivered a beat with no read pending"});
    end else begin
      check_ret(name, got, '{valid: 1'b1, last: (cnt[p] == beats[p] - 1),
                data: shadow[word_idx(base[p]) + 10'(cnt[p])]});
      cnt[p]++;
      if (cnt[p] == beats[p]) begin
        pend[p] = 1'b0;
      end
    end
  endtask

  // shadow takes the write as soon as it is accepted
  task automatic open_write(input wr_req_t req);
    wr_q      = req;
    wr_beat   = 0;
    wr_pend   = 1'b1;
    wr_window = 1'b1;
    if (req.req_type == rd_type_line) begin
      for (int k = 0; k < 4; k++) begin
        shadow[word_idx(req.addr) + 10'(k)] = req.payload.line[k*32 +: 32];
      end
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (req.strb[k]) begin
          shadow[word_idx(req.addr)][k*8 +: 8] = req.payload.line[k*8 +: 8];
        end
      end
    end
  endtask

  always @(posedge aclk) begin
    if (reset) begin
      value_errs     = 0;
      proto_errs     = 0;
      pend[0]        = 1'b0;
      pend[1]        = 1'b0;
      wr_pend        = 1'b0;
      wr_window      = 1'b0;
      inst_in_window = 0;
      for (int i = 0; i < 1024; i++) begin
        shadow[i] = mem_model.mem[i];
      end
    end else begin
      if (wr_window && data_rd_rdy) begin
        protocol_fault("data read port was ready while a write was in flight");
      end
      if (inst_rd_req && inst_rd_rdy) begin
        open_read(0, id_inst, inst_rd);
        if (wr_window) begin
          inst_in_window++;
        end
      end
      if (data_rd_req && data_rd_rdy) begin
        open_read(1, id_data, data_rd);
      end
      if (arvalid && arready) begin
        check_ar(ar, exp_ar);
        ar_ids.push_back(ar.id);
      end
      if (inst_ret.valid) begin
        take_ret(0, "inst_ret", inst_ret);
      end
      if (data_ret.valid) begin
        take_ret(1, "data_ret", data_ret);
      end
      if (data_wr_req && data_wr_rdy) begin
        open_write(data_wr);
      end
      if (awvalid && awready) begin
        check_aw(aw, expect_addr(id_data, wr_q.req_type, wr_q.addr));
      end
      if (wvalid && wready) begin
        check_w(w, expect_beat(wr_q, wr_beat));
        wr_beat++;
      end
      if (bvalid && bready) begin
        wr_pend   = 1'b0;
        wr_window = 1'b0;
      end
    end
  end

  // starts and ends on a falling edge once the read has come back
  task automatic read_port(input int p, input rd_req_t req);
    if (p == 0) begin
      inst_rd_req = 1'b1;
      inst_rd     = req;
    end else begin
      data_rd_req = 1'b1;
      data_rd     = req;
    end
    @(posedge aclk);
    while (!((p == 0) ? inst_rd_rdy : data_rd_rdy)) @(posedge aclk);
    @(negedge aclk);
    if (p == 0) begin
      inst_rd_req = 1'b0;
    end else begin
      data_rd_req = 1'b0;
    end
    while (pend[p]) @(negedge aclk);
  endtask

  task automatic write_port(input wr_req_t req);
    data_wr_req = 1'b1;
    data_wr     = req;
    @(posedge aclk);
    while (!data_wr_rdy) @(posedge aclk);
    @(negedge aclk);
    data_wr_req = 1'b0;
    while (wr_pend) @(negedge aclk);
  endtask

  task automatic data_traffic();
    rd_req_t rd;
    wr_req_t wr;
    repeat (n_data) begin
      if ($urandom % 2 == 0) begin
        wr = random_write(32'h800);
        write_port(wr);
        // read back the merged result
        rd.req_type = wr.req_type;
        rd.addr     = wr.addr;
        read_port(1, rd);
      end else begin
        read_port(1, random_read(32'h800));
      end
    end
  endtask

  initial begin
    rd_req_t tie_inst;
    rd_req_t tie_data;
    void'($urandom(32'h23dc_8b6b));
    reset       = 1'b1;
    inst_rd_req = 1'b0;
    inst_rd     = '0;
    data_rd_req = 1'b0;
    data_rd     = '0;
    data_wr_req = 1'b0;
    data_wr     = '0;
    flow_errs   = 0;
    repeat (5) @(negedge aclk);
    reset = 1'b0;
    @(negedge aclk);
    if (!bridge_idle()) begin
      flow_fault("bridge outputs were not idle after reset");
    end
    // both read ports raised in one idle cycle
    tie_inst = random_read(32'h0);
    tie_data = random_read(32'h800);
    fork
      read_port(0, tie_inst);
      read_port(1, tie_data);
    join
    if (ar_ids.size() != 2 || ar_ids[0] != id_data || ar_ids[1] != id_inst) begin
      flow_fault("data read did not win the tie against the instruction read");
    end
    fork
      repeat (n_inst) read_port(0, random_read(32'h0));
      data_traffic();
    join
    repeat (4) @(negedge aclk);
    if (inst_in_window == 0) begin
      flow_fault("no instruction read was accepted while a write was in flight");
    end
    if (!bridge_idle()) begin
      flow_fault("bridge did not return to idle after the last transaction");
    end
    $display("errors: %0d value, %0d protocol, %0d flow", value_errs, proto_errs, flow_errs);
    if (value_errs + proto_errs + flow_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem
  import axi_bridge_pkg::*;
(
  input  logic    aclk,
  input  logic    reset,
  input  axi_ar_t ar,
  input  logic    arvalid,
  output logic    arready,
  output axi_r_t  r,
  output logic    rvalid,
  input  logic    rready,
  input  axi_aw_t aw,
  input  logic    awvalid,
  output logic    awready,
  input  axi_w_t  w,
  input  logic    wvalid,
  output logic    wready,
  output axi_b_t  b,
  output logic    bvalid,
  input  logic    bready
);

  logic [data_w-1:0] mem [0:1023];

  logic              ar_fire, r_fire, aw_fire, w_fire, b_fire;
  axi_ar_t           ar_q;
  axi_aw_t           aw_q;
  axi_w_t            w_q;
  logic [1:0]        ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic              rd_busy, wr_busy, b_pend;
  logic [addr_w-1:0] rd_addr, wr_addr;
  logic [3:0]        rd_id, b_id;
  logic [7:0]        rd_left;

  // handshakes seen at the rising edge, acted on at the next falling edge
  always @(posedge aclk) begin
    ar_fire <= arvalid && arready;
    r_fire  <= rvalid && rready;
    aw_fire <= awvalid && awready;
    w_fire  <= wvalid && wready;
    b_fire  <= bvalid && bready;
    ar_q    <= ar;
    aw_q    <= aw;
    w_q     <= w;
  end

  initial begin
    // fill pattern covers every address bit
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'(i) * 32'h9e37_79b9 + 32'h1357_9bdf;
    end
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    b       = '0;
    forever begin
      @(negedge aclk);
      if (reset) begin
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        b_pend  = 1'b0;
        ar_wait = 2'd0;
        aw_wait = 2'd0;
      end else begin
        // read side
        if (r_fire) begin
          rvalid  = 1'b0;
          rd_addr = rd_addr + 32'd4;
          rd_left = rd_left - 8'd1;
          rd_busy = (rd_left != 8'd0);
          r_wait  = 2'($urandom % 4);
        end
        if (ar_fire) begin
          arready = 1'b0;
          ar_wait = 2'($urandom % 4);
          rd_busy = 1'b1;
          rd_addr = ar_q.addr;
          rd_id   = ar_q.id;
          rd_left = ar_q.len + 8'd1;
          r_wait  = 2'($urandom % 4);
        end else if (!rd_busy && !arready) begin
          if (ar_wait == 2'd0) begin
            arready = 1'b1;
          end else begin
            ar_wait = ar_wait - 2'd1;
          end
        end
        if (rd_busy && !rvalid) begin
          if (r_wait == 2'd0) begin
            rvalid = 1'b1;
            r = '{id: rd_id, data: mem[rd_addr[11:2]], resp: 2'b00, last: rd_left == 8'd1};
          end else begin
            r_wait = r_wait - 2'd1;
          end
        end
        // write side
        if (b_fire) begin
          bvalid  = 1'b0;
          b_pend  = 1'b0;
          wr_busy = 1'b0;
        end
        if (w_fire) begin
          for (int k = 0; k < strb_w; k++) begin
            if (w_q.strb[k]) begin
              mem[wr_addr[11:2]][k*8 +: 8] = w_q.data[k*8 +: 8];
            end
          end
          wr_addr = wr_addr + 32'd4;
          wready  = 1'b0;
          w_wait  = 2'($urandom % 4);
          if (w_q.last) begin
            b_pend = 1'b1;
            b_wait = 2'($urandom % 4);
          end
        end
        if (aw_fire) begin
          awready = 1'b0;
          aw_wait = 2'($urandom % 4);
          wr_busy = 1'b1;
          wr_addr = aw_q.addr;
          b_id    = aw_q.id;
          w_wait  = 2'($urandom % 4);
        end else if (!wr_busy && !awready) begin
          if (aw_wait == 2'd0) begin
            awready = 1'b1;
          end else begin
            aw_wait = aw_wait - 2'd1;
          end
        end
        if (wr_busy && !b_pend && !wready) begin
          if (w_wait == 2'd0) begin
            wready = 1'b1;
          end else begin
            w_wait = w_wait - 2'd1;
          end
        end
        if (b_pend && !bvalid) begin
          if (b_wait == 2'd0) begin
            bvalid = 1'b1;
            b = '{id: b_id, resp: 2'b00};
          end else begin
            b_wait = b_wait - 2'd1;
          end
        end
      end
    end
  end

endmodule

// ==== axi_bridge_top.sv ====
`timescale 1ns/1ps

module axi_bridge_top
  import axi_bridge_pkg::*;
(
  input  logic    aclk,
  input  logic    reset,
  // instruction cache reads
  input  logic    inst_rd_req,
  input  rd_req_t inst_rd,
  output logic    inst_rd_rdy,
  // data cache reads and writes
  input  logic    data_rd_req,
  input  rd_req_t data_rd,
  output logic    data_rd_rdy,
  input  logic    data_wr_req,
  input  wr_req_t data_wr,
  output logic    data_wr_rdy,
  output rd_ret_t inst_ret,
  output rd_ret_t data_ret,
  // axi3 master
  output axi_ar_t ar,
  output logic    arvalid,
  input  logic    arready,
  input  axi_r_t  r,
  input  logic    rvalid,
  output logic    rready,
  output axi_aw_t aw,
  output logic    awvalid,
  input  logic    awready,
  output axi_w_t  w,
  output logic    wvalid,
  input  logic    wready,
  input  axi_b_t  b,
  input  logic    bvalid,
  output logic    bready
);

  logic       wr_busy;
  logic       wr_load;
  logic [1:0] beat_idx;
  logic       beat_last;

  rd_channel_fsm u_rd_fsm (
    .aclk        (aclk),
    .reset       (reset),
    .inst_rd_req (inst_rd_req),
    .inst_rd     (inst_rd),
    .inst_rd_rdy (inst_rd_rdy),
    .data_rd_req (data_rd_req),
    .data_rd     (data_rd),
    .data_rd_rdy (data_rd_rdy),
    .wr_busy     (wr_busy),
    .ar          (ar),
    .arvalid     (arvalid),
    .arready     (arready),
    .r           (r),
    .rvalid      (rvalid),
    .rready      (rready),
    .inst_ret    (inst_ret),
    .data_ret    (data_ret)
  );

  wr_channel_fsm u_wr_fsm (
    .aclk         (aclk),
    .reset        (reset),
    .data_wr_req  (data_wr_req),
    .data_wr_type (data_wr.req_type),
    .data_wr_rdy  (data_wr_rdy),
    .wr_busy      (wr_busy),
    .load         (wr_load),
    .beat_last    (beat_last),
    .aw_addr      (data_wr.addr),
    .aw           (aw),
    .awvalid      (awvalid),
    .awready      (awready),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  beat_counter u_beat_cnt (
    .aclk      (aclk),
    .reset     (reset),
    .load      (wr_load),
    .line      (data_wr.req_type == rd_type_line),
    .advance   (wvalid & wready),
    .beat_idx  (beat_idx),
    .beat_last (beat_last)
  );

  wr_line_buffer u_wr_buf (
    .aclk      (aclk),
    .reset     (reset),
    .load      (wr_load),
    .data_wr   (data_wr),
    .beat_idx  (beat_idx),
    .beat_last (beat_last),
    .w         (w)
  );

endmodule

// ==== wr_line_buffer.sv ====
`timescale 1ns/1ps

module wr_line_buffer
  import axi_bridge_pkg::*;
(
  input  logic       aclk,
  input  logic       reset,
  input  logic       load,
  input  wr_req_t    data_wr,
  input  logic [1:0] beat_idx,
  input  logic       beat_last,
  output axi_w_t     w
);

  wr_payload_u       payload_q;
  logic [strb_w-1:0] strb_q;

  // line writes always carry every byte
  always_ff @(posedge aclk) begin
    if (reset) begin
      strb_q <= '0;
    end else if (load) begin
      if (data_wr.req_type == rd_type_line) begin
        strb_q <= '1;
      end else begin
        strb_q <= data_wr.strb;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      payload_q.line <= data_wr.payload.line;
    end
  end

  // word view of the stored line, one per beat
  assign w = '{
    id:   id_data,
    data: payload_q.words[beat_idx],
    strb: strb_q,
    last: beat_last
  };

endmodule

// ==== beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter
  import axi_bridge_pkg::*;
(
  input  logic       aclk,
  input  logic       reset,
  input  logic       load,
  input  logic       line,
  input  logic       advance,
  output logic [1:0] beat_idx,
  output logic       beat_last
);

  // beats still to send, up to a full line
  logic [2:0] remaining;

  always_ff @(posedge aclk) begin
    if (reset) begin
      remaining <= 3'd0;
      beat_idx  <= 2'd0;
    end else if (load) begin
      remaining <= line ? 3'(line_words) : 3'd1;
      beat_idx  <= 2'd0;
    end else if (advance) begin
      remaining <= remaining - 3'd1;
      beat_idx  <= beat_idx + 2'd1;
    end
  end

  assign beat_last = (remaining == 3'd1);

endmodule

// ==== wr_channel_fsm.sv ====
`timescale 1ns/1ps

module wr_channel_fsm
  import axi_bridge_pkg::*;
(
  input  logic              aclk,
  input  logic              reset,
  input  logic              data_wr_req,
  input  logic [2:0]        data_wr_type,
  output logic              data_wr_rdy,
  output logic              wr_busy,
  output logic              load,
  input  logic              beat_last,
  input  logic [addr_w-1:0] aw_addr,
  output axi_aw_t           aw,
  output logic              awvalid,
  input  logic              awready,
  output logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  output logic              bready
);

  logic [1:0] state;

  assign data_wr_rdy = (state == st_idle);
  assign load        = data_wr_req && data_wr_rdy;
  assign wr_busy     = (state != st_idle);

  assign awvalid = (state == st_addr);
  assign wvalid  = (state == st_data);
  assign bready  = (state == st_resp);

  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (load) begin
            state <= st_addr;
          end
        end
        st_addr: begin
          if (awready) begin
            state <= st_data;
          end
        end
        st_data: begin
          // last beat comes from the counter
          if (wready && beat_last) begin
            state <= st_resp;
          end
        end
        st_resp: begin
          if (bvalid) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      aw <= '{
        id:    id_data,
        addr:  aw_addr,
        len:   (data_wr_type == rd_type_line) ? axi_len_line : axi_len_word,
        size:  size_word,
        burst: burst_incr,
        lock:  lock_normal,
        cache: cache_attr,
        prot:  prot_attr
      };
    end
  end

endmodule

// ==== rd_channel_fsm.sv ====
`timescale 1ns/1ps

module rd_channel_fsm
  import axi_bridge_pkg::*;
(
  input  logic    aclk,
  input  logic    reset,
  input  logic    inst_rd_req,
  input  rd_req_t inst_rd,
  output logic    inst_rd_rdy,
  input  logic    data_rd_req,
  input  rd_req_t data_rd,
  output logic    data_rd_rdy,
  input  logic    wr_busy,
  output axi_ar_t ar,
  output logic    arvalid,
  input  logic    arready,
  input  axi_r_t  r,
  input  logic    rvalid,
  output logic    rready,
  output rd_ret_t inst_ret,
  output rd_ret_t data_ret
);

  logic [1:0] state;
  logic       data_take;
  logic       inst_take;
  logic       r_fire;
  rd_req_t    win_req;
  logic [3:0] win_id;

  // data reads wait for the write path to drain
  assign data_rd_rdy = (state == st_idle) && !wr_busy;
  // data wins a tie, so instruction side backs off
  assign inst_rd_rdy = (state == st_idle) && !(data_rd_req && data_rd_rdy);

  assign data_take = data_rd_req && data_rd_rdy;
  assign inst_take = inst_rd_req && inst_rd_rdy;

  assign win_req = data_take ? data_rd : inst_rd;
  assign win_id  = data_take ? id_data : id_inst;

  assign arvalid = (state == st_addr);
  assign rready  = (state == st_data);
  assign r_fire  = rvalid && rready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (data_take || inst_take) begin
            state <= st_addr;
          end
        end
        st_addr: begin
          if (arready) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (r_fire && r.last) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ar held steady from acceptance until arready
  always_ff @(posedge aclk) begin
    if (data_take || inst_take) begin
      ar <= '{
        id:    win_id,
        addr:  win_req.addr,
        len:   (win_req.req_type == rd_type_line) ? axi_len_line : axi_len_word,
        size:  size_word,
        burst: burst_incr,
        lock:  lock_normal,
        cache: cache_attr,
        prot:  prot_attr
      };
    end
  end

  // steer each beat by rid, same cycle
  assign inst_ret = '{
    valid: r_fire && (r.id == id_inst),
    last:  r.last,
    data:  r.data
  };

  assign data_ret = '{
    valid: r_fire && (r.id == id_data),
    last:  r.last,
    data:  r.data
  };

endmodule

// ==== axi_bridge_pkg.sv ====
package axi_bridge_pkg;

  // bus widths
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int line_words = 4;
  localparam int strb_w     = data_w / 8;

  // request type from the caches; anything but this is a single word
  localparam logic [2:0] rd_type_line = 3'b100;

  // axi ids per traffic class
  localparam logic [3:0] id_inst = 4'd0;
  localparam logic [3:0] id_data = 4'd1;

  // fixed axi attributes
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [2:0] size_word   = 3'b010;
  localparam logic [3:0] cache_attr  = 4'b0000;
  localparam logic [2:0] prot_attr   = 3'b000;
  localparam logic [1:0] lock_normal = 2'b00;

  localparam logic [7:0] axi_len_line = 8'd3;
  localparam logic [7:0] axi_len_word = 8'd0;

  // state codes shared by the read and write FSMs
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_addr = 2'd1;
  localparam logic [1:0] st_data = 2'd2;
  localparam logic [1:0] st_resp = 2'd3;

  typedef struct packed {
    logic [2:0]        req_type;
    logic [addr_w-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic              valid;
    logic              last;
    logic [data_w-1:0] data;
  } rd_ret_t;

  // request side fills the line, W channel picks a word per beat
  typedef union packed {
    logic [line_words*data_w-1:0]     line;
    logic [line_words-1:0][data_w-1:0] words;
  } wr_payload_u;

  typedef struct packed {
    logic [2:0]        req_type;
    logic [addr_w-1:0] addr;
    logic [strb_w-1:0] strb;
    wr_payload_u       payload;
  } wr_req_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [addr_w-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [1:0]        lock;
    logic [3:0]        cache;
    logic [2:0]        prot;
  } axi_ar_t;

  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [data_w-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    logic [3:0] id;
    logic [1:0] resp;
  } axi_b_t;

endpackage
